/* design/ppu_pkg.sv */
// Shared definitions for the pixel output path
// LCD word struct carried from the register block to the serialiser
// Pixel, colour and fill count widths
// APB register offsets and CSR bit positions

package ppu_pkg;

	// ----------------------------------------
	// Widths

	// One LCD word as shifted onto the link
	localparam int W_PIXEL = 16;
	// RGB555 fill colour
	localparam int W_COLOUR = 15;
	// Pixel count of one fill run
	localparam int W_FILLCNT = 16;
	// One RGB555 channel
	localparam int W_CHAN = 5;

	// Word held in the pixel FIFO
	typedef struct packed {
		// 0 command, 1 data
		logic dc;
		logic [W_PIXEL-1:0] data;
	} lcd_word_t;

	// ----------------------------------------
	// APB register map

	localparam logic [15:0] REG_CSR = 16'h0000;
	localparam logic [15:0] REG_FILLCOL = 16'h0004;
	localparam logic [15:0] REG_FILLCNT = 16'h0008;
	localparam logic [15:0] REG_PXFIFO = 16'h000c;
	localparam logic [15:0] REG_STATUS = 16'h0010;
	localparam logic [15:0] REG_INTS = 16'h0014;
	localparam logic [15:0] REG_INTE = 16'h0018;

	// CSR fields
	// Write 1 starts a fill, reads as 0
	localparam int CSR_FILL_RUN = 0;
	localparam int CSR_FILL_BUSY = 1;
	// Chip select, high out of reset
	localparam int CSR_LCD_CS = 2;
	localparam int CSR_LCD_DC = 3;
	localparam int CSR_SHIFT8 = 4;
	localparam int CSR_TX_BUSY = 5;

endpackage

/* design/ppu_cdc_sync.sv */
// Reset synchroniser with asynchronous assert
// Two-flop level synchroniser for W_SYNC bits

`timescale 1ns/1ps

module ppu_cdc_sync #(
	parameter int W_SYNC = 1
) (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic [W_SYNC-1:0] d_i,
	output logic              rst_sync_n_o,
	output logic [W_SYNC-1:0] q_o
);

	logic rst_s1;
	logic [W_SYNC-1:0] d_s1;

	// Release through two flops
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rst_s1 <= 1'b0;
			rst_sync_n_o <= 1'b0;
		end else begin
			rst_s1 <= 1'b1;
			rst_sync_n_o <= rst_s1;
		end
	end

	// Level sync, bits only meaningful when quasi-static
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			d_s1 <= '0;
			q_o <= '0;
		end else begin
			d_s1 <= d_i;
			q_o <= d_s1;
		end
	end

endmodule

/* design/ppu_fill.sv */
// Solid colour fill engine
// RGB555 to RGB565 conversion of the fill colour
// Pixel counter, one word per granted cycle

`timescale 1ns/1ps

module ppu_fill (
	input  logic                          clk_ppu_i,
	input  logic                          rst_n_i,
	input  logic                          start_i,
	input  logic [ppu_pkg::W_COLOUR-1:0]  colour_i,
	input  logic [ppu_pkg::W_FILLCNT-1:0] count_i,
	input  logic                          grant_i,
	output logic                          vld_o,
	output logic [ppu_pkg::W_PIXEL-1:0]   px_o,
	output logic                          busy_o
);

	import ppu_pkg::*;

	logic busy_q;
	logic start;
	logic [W_FILLCNT-1:0] count_q;
	logic [W_PIXEL-1:0] px_q;
	logic [W_PIXEL-1:0] px_565;

	// Red and green move up one place
	// Zero becomes the new low green bit
	assign px_565 = {colour_i[W_COLOUR-1:W_CHAN], 1'b0, colour_i[W_CHAN-1:0]};

	// Start is ignored while a run is going
	assign start = start_i & ~busy_q;

	// One pixel per granted cycle
	assign vld_o = busy_q & grant_i;
	assign px_o = px_q;
	assign busy_o = busy_q;

	always_ff @(posedge clk_ppu_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			busy_q <= 1'b0;
			count_q <= '0;
		end else if (start) begin
			// Zero count gives no run at all
			busy_q <= count_i != '0;
			count_q <= count_i;
		end else if (vld_o) begin
			count_q <= count_q - 1'b1;
			if (count_q == W_FILLCNT'(1))
				busy_q <= 1'b0;
		end
	end

	// Pixel value held for the whole run
	always_ff @(posedge clk_ppu_i) begin
		if (start)
			px_q <= px_565;
	end

endmodule

/* design/ppu_pxfifo.sv */
// Dual-clock pixel FIFO of LCD words
// Gray-coded pointers with two-flop synchronisers both ways
// Write-side credit count of free entries
// Read side shows the head word with a valid flag

`timescale 1ns/1ps

module ppu_pxfifo #(
	parameter int PXFIFO_DEPTH = 8,
	localparam int W_CREDIT = $clog2(PXFIFO_DEPTH + 1)
) (
	// Write side, clk_ppu
	input  logic                  clk_ppu_i,
	input  logic                  rst_ppu_n_i,
	input  logic                  push_i,
	input  ppu_pkg::lcd_word_t    wr_word_i,
	output logic [W_CREDIT-1:0]   credit_o,

	// Read side, clk_lcd
	input  logic                  clk_lcd_i,
	input  logic                  rst_lcd_n_i,
	input  logic                  pop_i,
	output logic                  rd_vld_o,
	output ppu_pkg::lcd_word_t    rd_word_o
);

	import ppu_pkg::*;

	localparam int W_ADDR = $clog2(PXFIFO_DEPTH);
	// Extra bit tells full from empty
	localparam int W_PTR = W_ADDR + 1;
	localparam logic [W_PTR-1:0] DEPTH_PTR = W_PTR'(PXFIFO_DEPTH);

	lcd_word_t mem [PXFIFO_DEPTH];

	logic [W_PTR-1:0] wptr_bin;
	logic [W_PTR-1:0] wptr_bin_nxt;
	logic [W_PTR-1:0] wptr_gray;
	logic [W_PTR-1:0] rptr_gray_s1;
	logic [W_PTR-1:0] rptr_gray_s2;
	logic [W_PTR-1:0] level;

	logic [W_PTR-1:0] rptr_bin;
	logic [W_PTR-1:0] rptr_bin_nxt;
	logic [W_PTR-1:0] rptr_gray;
	logic [W_PTR-1:0] wptr_gray_s1;
	logic [W_PTR-1:0] wptr_gray_s2;

	function automatic logic [W_PTR-1:0] gray2bin(input logic [W_PTR-1:0] g);
		logic [W_PTR-1:0] b;
		b[W_PTR-1] = g[W_PTR-1];
		for (int i = W_PTR - 2; i >= 0; i--)
			b[i] = b[i+1] ^ g[i];
		return b;
	endfunction

	// ----------------------------------------
	// Write domain

	assign wptr_bin_nxt = wptr_bin + W_PTR'(push_i);

	always_ff @(posedge clk_ppu_i or negedge rst_ppu_n_i) begin
		if (!rst_ppu_n_i) begin
			wptr_bin <= '0;
			wptr_gray <= '0;
			rptr_gray_s1 <= '0;
			rptr_gray_s2 <= '0;
		end else begin
			wptr_bin <= wptr_bin_nxt;
			wptr_gray <= wptr_bin_nxt ^ (wptr_bin_nxt >> 1);
			rptr_gray_s1 <= rptr_gray;
			rptr_gray_s2 <= rptr_gray_s1;
		end
	end

	always_ff @(posedge clk_ppu_i) begin
		if (push_i)
			mem[wptr_bin[W_ADDR-1:0]] <= wr_word_i;
	end

	// Credit comes back once the read pointer is through the synchroniser
	assign level = wptr_bin - gray2bin(rptr_gray_s2);
	assign credit_o = W_CREDIT'(DEPTH_PTR - level);

	// ----------------------------------------
	// Read domain

	assign rptr_bin_nxt = rptr_bin + W_PTR'(pop_i);

	always_ff @(posedge clk_lcd_i or negedge rst_lcd_n_i) begin
		if (!rst_lcd_n_i) begin
			rptr_bin <= '0;
			rptr_gray <= '0;
			wptr_gray_s1 <= '0;
			wptr_gray_s2 <= '0;
		end else begin
			rptr_bin <= rptr_bin_nxt;
			rptr_gray <= rptr_bin_nxt ^ (rptr_bin_nxt >> 1);
			wptr_gray_s1 <= wptr_gray;
			wptr_gray_s2 <= wptr_gray_s1;
		end
	end

	// Entry is settled before its write pointer arrives here
	assign rd_vld_o = rptr_gray != wptr_gray_s2;
	assign rd_word_o = mem[rptr_bin[W_ADDR-1:0]];

endmodule

/* design/ppu_dispctrl.sv */
// LCD serialiser in the clk_lcd domain
// Pops one word from the pixel FIFO when idle
// Shifts 16 or 8 bits MSB first, two clocks per bit
// Holds dc for the whole word

`timescale 1ns/1ps

module ppu_dispctrl (
	input  logic               clk_lcd_i,
	input  logic               rst_n_i,
	input  logic               rd_vld_i,
	input  ppu_pkg::lcd_word_t rd_word_i,
	input  logic               shift8_i,
	output logic               pop_o,
	output logic               sck_o,
	output logic               mosi_o,
	output logic               dc_o,
	output logic               tx_busy_o
);

	import ppu_pkg::*;

	localparam int W_BITCNT = $clog2(W_PIXEL);

	logic pop_q;
	logic busy_q;
	// Low phase then high phase of each bit
	logic phase_q;
	logic w8_q;
	logic dc_q;
	logic last_bit;
	logic [W_BITCNT-1:0] bitcnt_q;
	logic [W_PIXEL-1:0] shreg_q;

	// 8-bit mode stops after the top byte
	assign last_bit = bitcnt_q == (w8_q ? W_BITCNT'(W_PIXEL / 2 - 1) : W_BITCNT'(W_PIXEL - 1));

	assign pop_o = pop_q;
	assign sck_o = phase_q;
	assign mosi_o = shreg_q[W_PIXEL-1];
	assign dc_o = dc_q;
	assign tx_busy_o = pop_q | busy_q;

	always_ff @(posedge clk_lcd_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pop_q <= 1'b0;
			busy_q <= 1'b0;
			phase_q <= 1'b0;
			w8_q <= 1'b0;
			dc_q <= 1'b0;
			bitcnt_q <= '0;
			shreg_q <= '0;
		end else begin
			// Pop in the cycle after valid is seen
			pop_q <= rd_vld_i & ~busy_q & ~pop_q;
			if (pop_q) begin
				busy_q <= 1'b1;
				phase_q <= 1'b0;
				bitcnt_q <= '0;
				shreg_q <= rd_word_i.data;
				dc_q <= rd_word_i.dc;
				// Width fixed per word
				w8_q <= shift8_i;
			end else if (busy_q) begin
				phase_q <= ~phase_q;
				// End of high phase, next bit goes out with sck low
				if (phase_q) begin
					shreg_q <= {shreg_q[W_PIXEL-2:0], 1'b0};
					bitcnt_q <= bitcnt_q + 1'b1;
					if (last_bit)
						busy_q <= 1'b0;
				end
			end
		end
	end

endmodule

/* design/ppu_regs.sv */
// APB register block of the pixel output path
// CSR, fill colour and count, interrupt status and enable
// Direct and fill words merged into a single FIFO push
// Credit grant towards the fill engine
// Fill-done interrupt

`timescale 1ns/1ps

module ppu_regs #(
	parameter int PXFIFO_DEPTH = 8,
	localparam int W_CREDIT = $clog2(PXFIFO_DEPTH + 1)
) (
	input  logic                          clk_ppu_i,
	input  logic                          rst_n_i,

	// APB slave
	input  logic                          psel_i,
	input  logic                          penable_i,
	input  logic                          pwrite_i,
	input  logic [15:0]                   paddr_i,
	input  logic [31:0]                   pwdata_i,
	output logic [31:0]                   prdata_o,
	output logic                          pready_o,
	output logic                          pslverr_o,

	// FIFO write side
	input  logic [W_CREDIT-1:0]           credit_i,
	output logic                          push_o,
	output ppu_pkg::lcd_word_t            push_word_o,

	// Fill engine
	output logic                          fill_start_o,
	output logic [ppu_pkg::W_COLOUR-1:0]  fill_colour_o,
	output logic [ppu_pkg::W_FILLCNT-1:0] fill_count_o,
	output logic                          fill_grant_o,
	input  logic                          fill_busy_i,
	input  logic                          fill_vld_i,
	input  logic [ppu_pkg::W_PIXEL-1:0]   fill_px_i,

	// LCD control
	input  logic                          tx_busy_i,
	output logic                          lcd_cs_o,
	output logic                          shift8_o,
	output logic                          irq_o
);

	import ppu_pkg::*;

	// STATUS layout above the credit count
	localparam int STATUS_EMPTY = 16;
	localparam int STATUS_FULL = 17;

	logic access;
	logic wr;
	logic mapped;
	logic credit_avail;
	logic direct_req;
	logic direct_push;
	logic csr_dc;
	logic inte_q;
	logic ints_q;
	logic ints_val;
	logic fill_busy_q;
	logic fill_done;

	// ----------------------------------------
	// APB decode

	// Transfer completes in the access phase
	assign access = psel_i & penable_i;
	assign wr = access & pwrite_i;
	assign pready_o = 1'b1;

	assign mapped = (paddr_i == REG_CSR) || (paddr_i == REG_FILLCOL) ||
		(paddr_i == REG_FILLCNT) || (paddr_i == REG_PXFIFO) ||
		(paddr_i == REG_STATUS) || (paddr_i == REG_INTS) || (paddr_i == REG_INTE);

	// Direct FIFO write needs a credit and an idle fill engine
	assign credit_avail = credit_i != '0;
	assign direct_req = wr && (paddr_i == REG_PXFIFO);
	assign direct_push = direct_req & credit_avail & ~fill_busy_i;

	// Refused direct writes are dropped
	assign pslverr_o = access & (~mapped | (direct_req & ~direct_push));

	// ----------------------------------------
	// Control registers

	always_ff @(posedge clk_ppu_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			lcd_cs_o <= 1'b1;
			csr_dc <= 1'b0;
			shift8_o <= 1'b0;
			fill_colour_o <= '0;
			fill_count_o <= '0;
			inte_q <= 1'b0;
			ints_q <= 1'b0;
			fill_busy_q <= 1'b0;
		end else begin
			fill_busy_q <= fill_busy_i;
			if (wr && (paddr_i == REG_CSR)) begin
				lcd_cs_o <= pwdata_i[CSR_LCD_CS];
				csr_dc <= pwdata_i[CSR_LCD_DC];
				shift8_o <= pwdata_i[CSR_SHIFT8];
			end
			if (wr && (paddr_i == REG_FILLCOL))
				fill_colour_o <= pwdata_i[W_COLOUR-1:0];
			if (wr && (paddr_i == REG_FILLCNT))
				fill_count_o <= pwdata_i[W_FILLCNT-1:0];
			if (wr && (paddr_i == REG_INTE))
				inte_q <= pwdata_i[0];
			// W1C, a new fill-done wins over the clear
			ints_q <= (ints_q & ~(wr && (paddr_i == REG_INTS) && pwdata_i[0])) | fill_done;
		end
	end

	assign fill_start_o = wr && (paddr_i == REG_CSR) && pwdata_i[CSR_FILL_RUN];

	// ----------------------------------------
	// Interrupt

	// Falling edge of busy marks the end of a run
	assign fill_done = fill_busy_q & ~fill_busy_i;
	// Status visible in the cycle busy drops
	assign ints_val = ints_q | fill_done;
	assign irq_o = ints_val & inte_q;

	// ----------------------------------------
	// Read mux

	always_comb begin
		prdata_o = '0;
		case (paddr_i)
			REG_CSR: begin
				prdata_o[CSR_FILL_BUSY] = fill_busy_i;
				prdata_o[CSR_LCD_CS] = lcd_cs_o;
				prdata_o[CSR_LCD_DC] = csr_dc;
				prdata_o[CSR_SHIFT8] = shift8_o;
				prdata_o[CSR_TX_BUSY] = tx_busy_i;
			end
			REG_FILLCOL: prdata_o[W_COLOUR-1:0] = fill_colour_o;
			REG_FILLCNT: prdata_o[W_FILLCNT-1:0] = fill_count_o;
			REG_STATUS: begin
				prdata_o[W_CREDIT-1:0] = credit_i;
				prdata_o[STATUS_EMPTY] = credit_i == W_CREDIT'(PXFIFO_DEPTH);
				prdata_o[STATUS_FULL] = ~credit_avail;
			end
			REG_INTS: prdata_o[0] = ints_val;
			REG_INTE: prdata_o[0] = inte_q;
			default: prdata_o = '0;
		endcase
	end

	// ----------------------------------------
	// FIFO push merge

	// Fill only gets the slot when no direct write takes it
	assign fill_grant_o = credit_avail & ~direct_push;
	assign push_o = direct_push | fill_vld_i;

	always_comb begin
		if (direct_push) begin
			push_word_o.dc = csr_dc;
			push_word_o.data = pwdata_i[W_PIXEL-1:0];
		end else begin
			// Fill pixels are always data
			push_word_o.dc = 1'b1;
			push_word_o.data = fill_px_i;
		end
	end

endmodule

/* design/ppu_top.sv */
// Pixel output path top level
// Reset and level synchronisers for both clock domains
// Register block and fill engine on clk_ppu
// Pixel FIFO across to clk_lcd and the LCD serialiser

`timescale 1ns/1ps

module ppu_top #(
	parameter int PXFIFO_DEPTH = 8
) (
	input  logic        clk_ppu_i,
	input  logic        clk_lcd_i,
	input  logic        rst_n_i,

	// APB slave
	input  logic        psel_i,
	input  logic        penable_i,
	input  logic        pwrite_i,
	input  logic [15:0] paddr_i,
	input  logic [31:0] pwdata_i,
	output logic [31:0] prdata_o,
	output logic        pready_o,
	output logic        pslverr_o,

	output logic        irq_o,

	// LCD link
	output logic        lcd_cs_o,
	output logic        lcd_dc_o,
	output logic        lcd_sck_o,
	output logic        lcd_mosi_o
);

	import ppu_pkg::*;

	localparam int W_CREDIT = $clog2(PXFIFO_DEPTH + 1);

	logic rst_ppu_n;
	logic rst_lcd_n;
	logic tx_busy_lcd;
	logic tx_busy_ppu;
	logic shift8_ppu;
	logic shift8_lcd;

	logic [W_CREDIT-1:0] credit;
	logic push;
	lcd_word_t push_word;
	logic rd_vld;
	lcd_word_t rd_word;
	logic pop;

	logic fill_start;
	logic [W_COLOUR-1:0] fill_colour;
	logic [W_FILLCNT-1:0] fill_count;
	logic fill_grant;
	logic fill_vld;
	logic [W_PIXEL-1:0] fill_px;
	logic fill_busy;

	// ----------------------------------------
	// Domain crossings

	// Serialiser busy flag into clk_ppu
	ppu_cdc_sync #(.W_SYNC(1)) u_sync_ppu (
		.clk_i        (clk_ppu_i),
		.rst_n_i      (rst_n_i),
		.d_i          (tx_busy_lcd),
		.rst_sync_n_o (rst_ppu_n),
		.q_o          (tx_busy_ppu)
	);

	// Shift width only changes while the link is idle
	ppu_cdc_sync #(.W_SYNC(1)) u_sync_lcd (
		.clk_i        (clk_lcd_i),
		.rst_n_i      (rst_n_i),
		.d_i          (shift8_ppu),
		.rst_sync_n_o (rst_lcd_n),
		.q_o          (shift8_lcd)
	);

	// ----------------------------------------
	// clk_ppu domain

	ppu_regs #(.PXFIFO_DEPTH(PXFIFO_DEPTH)) u_regs (
		.clk_ppu_i     (clk_ppu_i),
		.rst_n_i       (rst_ppu_n),
		.psel_i        (psel_i),
		.penable_i     (penable_i),
		.pwrite_i      (pwrite_i),
		.paddr_i       (paddr_i),
		.pwdata_i      (pwdata_i),
		.prdata_o      (prdata_o),
		.pready_o      (pready_o),
		.pslverr_o     (pslverr_o),
		.credit_i      (credit),
		.push_o        (push),
		.push_word_o   (push_word),
		.fill_start_o  (fill_start),
		.fill_colour_o (fill_colour),
		.fill_count_o  (fill_count),
		.fill_grant_o  (fill_grant),
		.fill_busy_i   (fill_busy),
		.fill_vld_i    (fill_vld),
		.fill_px_i     (fill_px),
		.tx_busy_i     (tx_busy_ppu),
		.lcd_cs_o      (lcd_cs_o),
		.shift8_o      (shift8_ppu),
		.irq_o         (irq_o)
	);

	ppu_fill u_fill (
		.clk_ppu_i (clk_ppu_i),
		.rst_n_i   (rst_ppu_n),
		.start_i   (fill_start),
		.colour_i  (fill_colour),
		.count_i   (fill_count),
		.grant_i   (fill_grant),
		.vld_o     (fill_vld),
		.px_o      (fill_px),
		.busy_o    (fill_busy)
	);

	// ----------------------------------------
	// FIFO and clk_lcd domain

	ppu_pxfifo #(.PXFIFO_DEPTH(PXFIFO_DEPTH)) u_pxfifo (
		.clk_ppu_i   (clk_ppu_i),
		.rst_ppu_n_i (rst_ppu_n),
		.push_i      (push),
		.wr_word_i   (push_word),
		.credit_o    (credit),
		.clk_lcd_i   (clk_lcd_i),
		.rst_lcd_n_i (rst_lcd_n),
		.pop_i       (pop),
		.rd_vld_o    (rd_vld),
		.rd_word_o   (rd_word)
	);

	ppu_dispctrl u_dispctrl (
		.clk_lcd_i (clk_lcd_i),
		.rst_n_i   (rst_lcd_n),
		.rd_vld_i  (rd_vld),
		.rd_word_i (rd_word),
		.shift8_i  (shift8_lcd),
		.pop_o     (pop),
		.sck_o     (lcd_sck_o),
		.mosi_o    (lcd_mosi_o),
		.dc_o      (lcd_dc_o),
		.tx_busy_o (tx_busy_lcd)
	);

endmodule

/* tests/ppu_tb_tasks.svh */
// APB transfer tasks driven on the falling clk_ppu edge
// Value check with error counting
// Expected LCD word queue and the RGB565 reference conversion
// Direct word sender that records what the link must show

`ifndef PPU_TB_TASKS_SVH
`define PPU_TB_TASKS_SVH

// Compare one value, report in hex on mismatch
task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
	checks++;
	assert (got === exp) else begin
		errors++;
		$display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
	end
endtask

// One APB transfer, setup then access phase
task automatic apb_transfer(input bit write, input logic [15:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
	@(negedge clk_ppu);
	psel = 1'b1;
	penable = 1'b0;
	pwrite = write;
	paddr = addr;
	pwdata = wdata;
	@(negedge clk_ppu);
	penable = 1'b1;
	// Sample well before the completing rise
	#2;
	rdata = prdata;
	err = pslverr;
	check_eq("pready_o", pready, 1);
	@(negedge clk_ppu);
	psel = 1'b0;
	penable = 1'b0;
	pwrite = 1'b0;
endtask

task automatic write_reg(input logic [15:0] addr, input logic [31:0] data, output logic err);
	logic [31:0] rd_unused;
	apb_transfer(1'b1, addr, data, rd_unused, err);
endtask

task automatic read_reg(input logic [15:0] addr, output logic [31:0] data, output logic err);
	apb_transfer(1'b0, addr, 32'h0, data, err);
endtask

// Word the receiver must see next
task automatic queue_word(input logic [15:0] data, input logic dc, input bit w8);
	exp_data.push_back(data);
	exp_dc.push_back(dc);
	exp_w8.push_back(w8);
endtask

// Red and green kept, zero as new low green bit
function automatic logic [15:0] rgb565_of(input logic [14:0] c);
	return {c[14:10], c[9:5], 1'b0, c[4:0]};
endfunction

// Random direct words, all expected to be accepted
task automatic send_direct(input logic dc, input bit w8, input int n);
	logic [15:0] w;
	logic err;
	repeat (n) begin
		w = 16'($urandom);
		write_reg(REG_PXFIFO, {16'h0, w}, err);
		check_eq("pslverr_o", err, 0);
		if (!err)
			queue_word(w, dc, w8);
	end
endtask

`endif

/* tests/ppu_tb.sv */
// Testbench for the pixel output path
// Two clocks, reset, APB stimulus and an LCD receiver model
// Direct words, 8-bit mode, fill runs, back-pressure and unmapped access

`timescale 1ns/1ps

module ppu_tb;

	import ppu_pkg::*;

	localparam int DEPTH = 8;
	localparam int STATUS_EMPTY = 16;
	localparam int IDLE_POLLS = 400;
	localparam int FILL_POLLS = 400;

	logic clk_ppu;
	logic clk_lcd;
	logic rst_n;
	logic psel;
	logic penable;
	logic pwrite;
	logic [15:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic irq;
	logic lcd_cs;
	logic lcd_dc;
	logic lcd_sck;
	logic lcd_mosi;

	int checks;
	int errors;
	int timeouts;
	int words;
	int rx_bits;
	logic [15:0] rx_word;
	logic [15:0] exp_data[$];
	logic exp_dc[$];
	bit exp_w8[$];

	`include "ppu_tb_tasks.svh"

	ppu_top #(.PXFIFO_DEPTH(DEPTH)) dut (
		.clk_ppu_i  (clk_ppu),
		.clk_lcd_i  (clk_lcd),
		.rst_n_i    (rst_n),
		.psel_i     (psel),
		.penable_i  (penable),
		.pwrite_i   (pwrite),
		.paddr_i    (paddr),
		.pwdata_i   (pwdata),
		.prdata_o   (prdata),
		.pready_o   (pready),
		.pslverr_o  (pslverr),
		.irq_o      (irq),
		.lcd_cs_o   (lcd_cs),
		.lcd_dc_o   (lcd_dc),
		.lcd_sck_o  (lcd_sck),
		.lcd_mosi_o (lcd_mosi)
	);

	// ----------------------------------------
	// Clocks with clk_lcd 3 ns behind clk_ppu

	always #4 clk_ppu = ~clk_ppu;

	always begin
		#3;
		forever #4 clk_lcd = ~clk_lcd;
	end

	// ----------------------------------------
	// LCD receiver model

	// Bit sampled as sck rises
	// Word width taken from the expected word
	always @(posedge lcd_sck) begin
		rx_word = {rx_word[14:0], lcd_mosi};
		rx_bits++;
		if (rx_bits == ((exp_data.size() != 0 && exp_w8[0]) ? 8 : 16)) begin
			rx_bits = 0;
			words++;
			assert (exp_data.size() != 0) else begin
				errors++;
				$display("word 0x%0h arrived on the LCD link with none expected", rx_word);
			end
			if (exp_data.size() != 0) begin
				if (exp_w8[0])
					check_eq("lcd_mosi_o word", rx_word[7:0], exp_data[0][15:8]);
				else
					check_eq("lcd_mosi_o word", rx_word, exp_data[0]);
				check_eq("lcd_dc_o", lcd_dc, exp_dc[0]);
				void'(exp_data.pop_front());
				void'(exp_dc.pop_front());
				void'(exp_w8.pop_front());
			end
		end
	end

	// ----------------------------------------
	// Wait helpers

	// All expected words received and serialiser quiet
	task automatic wait_link_idle();
		logic [31:0] status;
		logic [31:0] csr;
		logic err;
		bit idle;
		int polls;
		idle = 0;
		polls = 0;
		while (!idle && polls < IDLE_POLLS) begin
			read_reg(REG_STATUS, status, err);
			read_reg(REG_CSR, csr, err);
			idle = exp_data.size() == 0 && status[STATUS_EMPTY] && !csr[CSR_TX_BUSY];
			polls++;
		end
		if (!idle) begin
			timeouts++;
			$display("timeout: LCD link never went idle, %0d words missing", exp_data.size());
		end
	endtask

	task automatic wait_fill_done();
		logic [31:0] csr;
		logic err;
		int polls;
		polls = 0;
		csr = 32'h1 << CSR_FILL_BUSY;
		while (csr[CSR_FILL_BUSY] && polls < FILL_POLLS) begin
			read_reg(REG_CSR, csr, err);
			polls++;
		end
		if (csr[CSR_FILL_BUSY]) begin
			timeouts++;
			$display("timeout: fill engine still busy");
		end
	endtask

	// ----------------------------------------
	// Test sequence

	initial begin
		logic [31:0] rd;
		logic [31:0] csr_val;
		logic [15:0] w;
		logic [14:0] colour;
		logic err;
		int count;
		int refused;
		void'($urandom(74811));
		clk_ppu = 1'b0;
		clk_lcd = 1'b0;
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		checks = 0;
		errors = 0;
		timeouts = 0;
		words = 0;
		rx_bits = 0;
		rx_word = '0;
		repeat (5) @(posedge clk_ppu);
		@(negedge clk_ppu);
		rst_n = 1'b1;
		// Let both reset synchronisers release
		repeat (4) @(negedge clk_ppu);

		// Reset state
		check_eq("lcd_cs_o", lcd_cs, 1);
		check_eq("lcd_sck_o", lcd_sck, 0);
		check_eq("irq_o", irq, 0);
		read_reg(REG_STATUS, rd, err);
		check_eq("status", rd, (32'h1 << STATUS_EMPTY) | DEPTH);

		// Direct words as commands then as data
		for (int dc = 0; dc < 2; dc++) begin
			csr_val = 32'(dc) << CSR_LCD_DC;
			write_reg(REG_CSR, csr_val, err);
			send_direct(dc[0], 0, 4);
			wait_link_idle();
		end

		// 8-bit mode sends the top byte only
		write_reg(REG_CSR, csr_val | (32'h1 << CSR_SHIFT8), err);
		send_direct(1'b1, 1, 4);
		wait_link_idle();
		write_reg(REG_CSR, csr_val, err);

		// Fill runs with the interrupt masked then enabled
		for (int en = 0; en < 2; en++) begin
			colour = 15'($urandom);
			count = 1 + int'($urandom % 20);
			write_reg(REG_INTE, en, err);
			write_reg(REG_FILLCOL, colour, err);
			write_reg(REG_FILLCNT, count, err);
			repeat (count) queue_word(rgb565_of(colour), 1'b1, 0);
			// CSR dc low, fill pixels still go out as data
			write_reg(REG_CSR, 32'h1 << CSR_FILL_RUN, err);
			wait_fill_done();
			read_reg(REG_INTS, rd, err);
			check_eq("ints", rd, 1);
			check_eq("irq_o", irq, en);
			write_reg(REG_INTS, 1, err);
			read_reg(REG_INTS, rd, err);
			check_eq("ints", rd, 0);
			check_eq("irq_o", irq, 0);
			wait_link_idle();
		end
		write_reg(REG_CSR, csr_val, err);

		// Back-to-back writes past the FIFO depth
		refused = 0;
		for (int i = 0; i < 2 * DEPTH; i++) begin
			w = 16'($urandom);
			write_reg(REG_PXFIFO, {16'h0, w}, err);
			if (i < DEPTH)
				check_eq("pslverr_o", err, 0);
			if (err)
				refused++;
			else
				queue_word(w, 1'b1, 0);
		end
		assert (refused > 0) else begin
			errors++;
			$display("no direct write was refused although the FIFO had no credit left");
		end
		wait_link_idle();

		// Direct write refused while a long fill runs
		colour = 15'($urandom);
		write_reg(REG_FILLCOL, colour, err);
		write_reg(REG_FILLCNT, 20, err);
		repeat (20) queue_word(rgb565_of(colour), 1'b1, 0);
		write_reg(REG_CSR, csr_val | (32'h1 << CSR_FILL_RUN), err);
		write_reg(REG_PXFIFO, 32'($urandom), err);
		check_eq("pslverr_o", err, 1);
		wait_fill_done();
		write_reg(REG_INTS, 1, err);
		wait_link_idle();

		// Unmapped offsets
		read_reg(16'h001c, rd, err);
		check_eq("pslverr_o", err, 1);
		write_reg(16'h0100, 32'h1234, err);
		check_eq("pslverr_o", err, 1);
		read_reg(REG_INTE, rd, err);
		check_eq("pslverr_o", err, 0);

		// Chip select low from the earlier CSR writes, then back high
		check_eq("lcd_cs_o", lcd_cs, 0);
		write_reg(REG_CSR, 32'h1 << CSR_LCD_CS, err);
		check_eq("lcd_cs_o", lcd_cs, 1);

		$display("checks %0d, words %0d, errors %0d, timeouts %0d",
			checks, words, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

/* build.f */
+incdir+tests
design/ppu_pkg.sv
design/ppu_cdc_sync.sv
design/ppu_fill.sv
design/ppu_pxfifo.sv
design/ppu_dispctrl.sv
design/ppu_regs.sv
design/ppu_top.sv
tests/ppu_tb.sv

/* Makefile */
SIM      := verilator
SIMFLAGS := --binary --timing --assert -Wno-fatal
TOP      := ppu_tb
FILELIST := build.f
OBJDIR   := obj_dir
LOG      := sim.log

BIN      := $(OBJDIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST)) tests/ppu_tb_tasks.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "tests failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -qx "all tests passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
